// ==== compile.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_regfile.sv
logic/csr_trap_ctrl.sv
logic/csr_stage.sv
sim/csr_properties.sv
sim/csr_checker.sv
sim/csr_stage_tb.sv

// ==== sim/csr_stage_tb.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_stage_tb;

    localparam int TIMEOUT_CYCLES  = 20;
    localparam int WATCHDOG_CYCLES = 2000;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]   rdata;
        logic                   stall;
        logic                   trap;
        logic [`CSR_XLEN-1:0]   vector;
    } expect_t;

    logic                   clk;
    logic                   rst;
    logic                   csr_valid;
    logic [`CSR_ID_W-1:0]   csr_inst_id;
    csr_pkg::csr_req_t      csr_req;
    logic [63:0]            cycle_count;
    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;
    logic [`CSR_XLEN-1:0]   csr_rdata;
    logic                   csr_stall;
    logic                   csr_trap;
    logic [`CSR_XLEN-1:0]   csr_trap_vector;

    expect_t                exp_q;
    logic                   check_en;
    logic                   seen_trap;
    logic [`CSR_ID_W-1:0]   next_id;
    int                     chk_errors;
    int                     other_fails;
    int                     tests_run;
    int                     tests_failed;
    int                     errs_before;

    // Reference model state
    csr_pkg::priv_mode_e    m_mode;
    csr_pkg::priv_mode_e    m_mpp;
    logic                   m_mie;
    logic                   m_mpie;
    logic                   m_mtie;
    logic                   m_mtip;
    logic                   m_redirect;
    logic [`CSR_ID_W-1:0]   m_saved_id;
    logic [`CSR_XLEN-1:0]   m_mtvec;
    logic [`CSR_XLEN-1:0]   m_mscratch;
    logic [`CSR_XLEN-1:0]   m_mepc;
    logic [`CSR_XLEN-1:0]   m_mcause;
    logic [`CSR_XLEN-1:0]   m_vec;

    csr_stage csr_stage_i (
        .clk             (clk),
        .rst             (rst),
        .csr_valid       (csr_valid),
        .csr_inst_id     (csr_inst_id),
        .csr_req         (csr_req),
        .cycle_count     (cycle_count),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .csr_rdata       (csr_rdata),
        .csr_stall       (csr_stall),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector)
    );

    csr_checker chk_i (
        .clk             (clk),
        .check_en        (check_en),
        .exp_rdata       (exp_q.rdata),
        .exp_stall       (exp_q.stall),
        .exp_trap        (exp_q.trap),
        .exp_vector      (exp_q.vector),
        .csr_valid       (csr_valid),
        .csr_rdata       (csr_rdata),
        .csr_stall       (csr_stall),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector),
        .error_count     (chk_errors)
    );

    bind csr_stage csr_properties props_i (
        .clk       (clk),
        .rst       (rst),
        .csr_valid (csr_valid),
        .csr_stall (csr_stall),
        .csr_trap  (csr_trap)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hang guard for the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic reset_model();
        m_mode     = csr_pkg::PRIV_MACHINE;
        m_mpp      = csr_pkg::PRIV_MACHINE;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mtie     = 1'b0;
        m_mtip     = 1'b0;
        m_redirect = 1'b0;
        m_saved_id = `CSR_ID_RESET;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_vec      = '0;
    endtask

    // Architectural view of one CSR before the access check
    function automatic logic [31:0] model_csr(input logic [11:0] addr);
        logic [31:0] v;
        v = '0;
        case (addr)
            `CSR_ADDR_MSTATUS: begin
                v[`CSR_MSTATUS_MIE_BIT]      = m_mie;
                v[`CSR_MSTATUS_MPIE_BIT]     = m_mpie;
                v[`CSR_MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            `CSR_ADDR_MISA:     v = `CSR_MISA_VALUE;
            `CSR_ADDR_MIE:      v[`CSR_MIE_MTIE_BIT] = m_mtie;
            `CSR_ADDR_MIP:      v[`CSR_MIP_MTIP_BIT] = m_mtip;
            `CSR_ADDR_MTVEC:    v = m_mtvec;
            `CSR_ADDR_MSCRATCH: v = m_mscratch;
            `CSR_ADDR_MEPC:     v = m_mepc;
            `CSR_ADDR_MCAUSE:   v = m_mcause;
            `CSR_ADDR_CYCLE, `CSR_ADDR_MCYCLE:   v = cycle_count[31:0];
            `CSR_ADDR_CYCLEH, `CSR_ADDR_MCYCLEH: v = cycle_count[63:32];
            default:            v = '0;
        endcase
        return v;
    endfunction

    function automatic void store_csr(input logic [11:0] addr, input logic [31:0] v);
        case (addr)
            `CSR_ADDR_MSTATUS: begin
                m_mie  = v[`CSR_MSTATUS_MIE_BIT];
                m_mpie = v[`CSR_MSTATUS_MPIE_BIT];
                // Only U and M exist so any nonzero MPP lands on M
                m_mpp  = (v[`CSR_MSTATUS_MPP_LSB +: 2] == 2'b00) ?
                         csr_pkg::PRIV_USER : csr_pkg::PRIV_MACHINE;
            end
            `CSR_ADDR_MIE:      m_mtie = v[`CSR_MIE_MTIE_BIT];
            `CSR_ADDR_MTVEC:    m_mtvec = v;
            `CSR_ADDR_MSCRATCH: m_mscratch = v;
            `CSR_ADDR_MEPC:     m_mepc = v & ~32'h3;
            `CSR_ADDR_MCAUSE:   m_mcause = v;
            default: begin
            end
        endcase
    endfunction

    function automatic void model_trap(input logic [31:0] cause, input logic [31:0] pc);
        m_mcause = cause;
        m_mepc   = pc;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mpp    = m_mode;
        m_mode   = csr_pkg::PRIV_MACHINE;
    endfunction

    // Expected outputs for this cycle and model advanced to the next edge
    function automatic expect_t predict(input logic valid, input logic [63:0] id,
                                        input csr_pkg::csr_req_t req);
        expect_t     e;
        logic        second;
        logic        irq;
        logic        readable;
        logic        writable;
        logic [31:0] old;
        logic [31:0] base;
        readable = req.addr[9:8] <= m_mode;
        writable = readable && (req.addr[11:10] != 2'b11);
        old      = model_csr(req.addr);
        second   = valid && m_redirect && (id == m_saved_id);
        irq      = m_mtip && m_mie && m_mtie;
        base     = {m_mtvec[31:2], 2'b00};
        e.rdata  = readable ? old : '0;
        e.stall  = 1'b0;
        e.trap   = second;
        e.vector = m_vec;
        if (valid && !second) begin
            if (irq) begin
                // Interrupt wins and the instruction's own write is dropped
                e.stall = 1'b1;
                m_vec   = (m_mtvec[1:0] == 2'b01) ? base + 32'd4 * 32'd7 : base;
                model_trap(`CSR_CAUSE_MTI, req.pc);
            end else if (req.cmd == csr_pkg::CSR_ECALL) begin
                e.stall = 1'b1;
                m_vec   = base;
                model_trap((m_mode == csr_pkg::PRIV_USER) ?
                           `CSR_CAUSE_ECALL_U : `CSR_CAUSE_ECALL_M, req.pc);
            end else if (req.cmd == csr_pkg::CSR_MRET) begin
                e.stall = 1'b1;
                m_vec   = m_mepc;
                m_mode  = m_mpp;
                m_mie   = m_mpie;
                m_mpie  = 1'b1;
                m_mpp   = csr_pkg::PRIV_USER;
            end else if (writable && (req.cmd != csr_pkg::CSR_X)) begin
                case (req.cmd)
                    csr_pkg::CSR_W: store_csr(req.addr, req.op1);
                    csr_pkg::CSR_S: store_csr(req.addr, old | req.op1);
                    default:        store_csr(req.addr, old & ~req.op1);
                endcase
            end
        end
        if (valid) begin
            m_saved_id = id;
            m_redirect = e.stall;
        end
        // Timer compare registered every clock
        m_mtip = (mtime >= mtimecmp);
        return e;
    endfunction

    function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_cmd_e cmd,
                                                    input logic [11:0] addr,
                                                    input logic [31:0] op1,
                                                    input logic [31:0] pc);
        csr_pkg::csr_req_t r;
        r.cmd  = cmd;
        r.addr = addr;
        r.op1  = op1;
        r.pc   = pc;
        return r;
    endfunction

    // Called 1 ns after a rising edge and returns 1 ns after the next one
    task automatic run_cycle(input logic valid, input logic [63:0] id,
                             input csr_pkg::csr_req_t req);
        csr_valid   = valid;
        csr_inst_id = id;
        csr_req     = req;
        cycle_count = {$urandom, $urandom};
        exp_q       = predict(valid, id, req);
        check_en    = 1'b1;
        @(negedge clk);
        seen_trap = csr_trap;
        @(posedge clk);
        #1;
    endtask

    task automatic csr_op(input csr_pkg::csr_cmd_e cmd, input logic [11:0] addr,
                          input logic [31:0] op1);
        run_cycle(1'b1, next_id, make_req(cmd, addr, op1, $urandom & ~32'h3));
        next_id++;
    endtask

    task automatic read_csr(input logic [11:0] addr);
        csr_op(csr_pkg::CSR_X, addr, 32'h0);
    endtask

    task automatic idle();
        run_cycle(1'b0, next_id, make_req(csr_pkg::CSR_X, 12'h0, 32'h0, 32'h0));
    endtask

    // Hold one instruction until the trap cycle shows up
    task automatic run_until_trap(input csr_pkg::csr_req_t req);
        int cycles;
        cycles    = 0;
        seen_trap = 1'b0;
        while (!seen_trap && (cycles < TIMEOUT_CYCLES)) begin
            run_cycle(1'b1, next_id, req);
            cycles++;
        end
        if (!seen_trap) begin
            $display("Timeout, no trap within %0d cycles for instruction id %0h",
                     TIMEOUT_CYCLES, next_id);
            other_fails++;
        end else if (cycles != 2) begin
            $display("Trap for instruction id %0h came after %0d cycles, not 2",
                     next_id, cycles);
            other_fails++;
        end
        next_id++;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = chk_errors + other_fails + csr_stage_i.props_i.assert_fails;
        tests_run++;
        if (errs != errs_before) begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errs - errs_before);
        end else begin
            $display("Test %0d %s: passed", tests_run, name);
        end
        errs_before = errs;
    endtask

    initial begin
        logic [11:0] addrs [10];
        logic [11:0] addr;
        int          total;
        void'($urandom(32'ha36d_4781));
        rst          = 1'b1;
        csr_valid    = 1'b0;
        csr_inst_id  = '0;
        csr_req      = '0;
        cycle_count  = '0;
        mtime        = {32'h1, $urandom};
        mtimecmp     = '1;
        check_en     = 1'b0;
        exp_q        = '0;
        next_id      = 64'h1;
        other_fails  = 0;
        tests_run    = 0;
        tests_failed = 0;
        errs_before  = 0;
        reset_model();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset values and counter views
        addrs = '{`CSR_ADDR_MISA, `CSR_ADDR_MSTATUS, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MTVEC,
                  `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH,
                  `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH};
        foreach (addrs[i]) begin
            read_csr(addrs[i]);
        end
        end_test("reset values");

        // Random W/S/C each followed by a read back
        addrs[0] = `CSR_ADDR_MSCRATCH;
        addrs[1] = `CSR_ADDR_MTVEC;
        addrs[2] = `CSR_ADDR_MEPC;
        for (int i = 0; i < 30; i++) begin
            addr = addrs[$urandom_range(2, 0)];
            csr_op(csr_pkg::csr_cmd_e'($urandom_range(3, 1)), addr, $urandom);
            read_csr(addr);
        end
        csr_op(csr_pkg::CSR_W, `CSR_ADDR_MISA, $urandom);
        read_csr(`CSR_ADDR_MISA);
        end_test("write set clear");

        // ECALL from machine mode with direct mtvec
        csr_op(csr_pkg::CSR_W, `CSR_ADDR_MTVEC, $urandom & ~32'h3);
        run_until_trap(make_req(csr_pkg::CSR_ECALL, 12'h0, 32'h0, $urandom & ~32'h3));
        read_csr(`CSR_ADDR_MCAUSE);
        read_csr(`CSR_ADDR_MEPC);
        end_test("ecall machine");

        // MPP to user then MRET, privilege check and ECALL back
        csr_op(csr_pkg::CSR_C, `CSR_ADDR_MSTATUS, 32'h0000_1800);
        run_until_trap(make_req(csr_pkg::CSR_MRET, 12'h0, 32'h0, $urandom & ~32'h3));
        read_csr(`CSR_ADDR_MSCRATCH);
        csr_op(csr_pkg::CSR_W, `CSR_ADDR_MSCRATCH, $urandom);
        run_until_trap(make_req(csr_pkg::CSR_ECALL, 12'h0, 32'h0, $urandom & ~32'h3));
        read_csr(`CSR_ADDR_MCAUSE);
        read_csr(`CSR_ADDR_MSCRATCH);
        read_csr(`CSR_ADDR_MSTATUS);
        end_test("mret and user mode");

        // Vectored timer interrupt against a pending mscratch write
        csr_op(csr_pkg::CSR_W, `CSR_ADDR_MTVEC, ($urandom & 32'hffff_ff00) | 32'h1);
        csr_op(csr_pkg::CSR_S, `CSR_ADDR_MIE, 32'h1 << `CSR_MIE_MTIE_BIT);
        csr_op(csr_pkg::CSR_S, `CSR_ADDR_MSTATUS, 32'h1 << `CSR_MSTATUS_MIE_BIT);
        mtimecmp = mtime - 64'd1;
        // MTIP shows up one clock after the compare
        idle();
        run_until_trap(make_req(csr_pkg::CSR_W, `CSR_ADDR_MSCRATCH, $urandom,
                                $urandom & ~32'h3));
        read_csr(`CSR_ADDR_MCAUSE);
        read_csr(`CSR_ADDR_MSTATUS);
        read_csr(`CSR_ADDR_MSCRATCH);
        // Timer still pending with MIE clear
        read_csr(`CSR_ADDR_MIP);
        mtimecmp = '1;
        end_test("timer interrupt");

        idle();
        total = chk_errors + other_fails + csr_stage_i.props_i.assert_fails;
        $display("Tests run %0d, failed %0d, value errors %0d, other failures %0d, assertions %0d",
                 tests_run, tests_failed, chk_errors, other_fails,
                 csr_stage_i.props_i.assert_fails);
        if ((tests_failed == 0) && (total == 0)) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/csr_checker.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_checker (
    input  logic                    clk,
    input  logic                    check_en,
    // Expected values from the reference model
    input  logic [`CSR_XLEN-1:0]    exp_rdata,
    input  logic                    exp_stall,
    input  logic                    exp_trap,
    input  logic [`CSR_XLEN-1:0]    exp_vector,
    // DUT ports under watch
    input  logic                    csr_valid,
    input  logic [`CSR_XLEN-1:0]    csr_rdata,
    input  logic                    csr_stall,
    input  logic                    csr_trap,
    input  logic [`CSR_XLEN-1:0]    csr_trap_vector,
    output int                      error_count
);

    initial begin
        error_count = 0;
    end

    task automatic report(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
        $display("[FAIL] time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        error_count++;
    endtask

    // Falling edge sits mid cycle, inputs and outputs settled
    always @(negedge clk) begin
        if (check_en) begin
            if (csr_stall !== exp_stall) begin
                report("csr_stall", {31'b0, exp_stall}, {31'b0, csr_stall});
            end
            if (csr_trap !== exp_trap) begin
                report("csr_trap", {31'b0, exp_trap}, {31'b0, csr_trap});
            end
            // Read data only means something with an instruction present
            if (csr_valid && (csr_rdata !== exp_rdata)) begin
                report("csr_rdata", exp_rdata, csr_rdata);
            end
            // Vector only defined in the trap cycle
            if (exp_trap && (csr_trap_vector !== exp_vector)) begin
                report("csr_trap_vector", exp_vector, csr_trap_vector);
            end
        end
    end

endmodule

// ==== sim/csr_properties.sv ====
`timescale 1ns/1ps

module csr_properties (
    input  logic    clk,
    input  logic    rst,
    input  logic    csr_valid,
    input  logic    csr_stall,
    input  logic    csr_trap
);

    // Failed assertions, read by the testbench at the end
    int assert_fails = 0;

    // A stall only ever holds a presented instruction
    stall_needs_valid: assert property (@(posedge clk) disable iff (rst) csr_stall |-> csr_valid)
        else begin
            $error("csr_stall high while csr_valid is low");
            assert_fails++;
        end

    // Stall cycle and trap cycle are distinct halves of a redirect
    stall_trap_exclusive: assert property (@(posedge clk) disable iff (rst) !(csr_stall && csr_trap))
        else begin
            $error("csr_stall and csr_trap high in the same cycle");
            assert_fails++;
        end

    // Trap only answers the repeated instruction
    trap_needs_valid: assert property (@(posedge clk) disable iff (rst) csr_trap |-> csr_valid)
        else begin
            $error("csr_trap high while csr_valid is low");
            assert_fails++;
        end

endmodule

// ==== logic/csr_stage.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    csr_valid,
    input  logic [`CSR_ID_W-1:0]    csr_inst_id,
    input  csr_pkg::csr_req_t       csr_req,
    input  logic [63:0]             cycle_count,
    input  logic [63:0]             mtime,
    input  logic [63:0]             mtimecmp,
    output logic [`CSR_XLEN-1:0]    csr_rdata,
    output logic                    csr_stall,
    output logic                    csr_trap,
    output logic [`CSR_XLEN-1:0]    csr_trap_vector
);

    // Controller to register file
    csr_pkg::trap_update_t  trap_update;
    csr_pkg::priv_mode_e    cur_mode;
    // Register file back to controller
    csr_pkg::csr_status_t   csr_status;

    // Mode, handshake and trap decisions
    csr_trap_ctrl trap_ctrl_i (
        .clk             (clk),
        .rst             (rst),
        .csr_valid       (csr_valid),
        .csr_inst_id     (csr_inst_id),
        .csr_req         (csr_req),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .status          (csr_status),
        .update          (trap_update),
        .mode            (cur_mode),
        .csr_stall       (csr_stall),
        .csr_trap        (csr_trap),
        .csr_trap_vector (csr_trap_vector)
    );

    // CSR storage and read path
    csr_regfile regfile_i (
        .clk         (clk),
        .rst         (rst),
        .req         (csr_req),
        .update      (trap_update),
        .mode        (cur_mode),
        .mtip        (trap_update.mtip),
        .cycle_count (cycle_count),
        .rdata       (csr_rdata),
        .status      (csr_status)
    );

endmodule

// ==== logic/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_trap_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    csr_valid,
    input  logic [`CSR_ID_W-1:0]    csr_inst_id,
    input  csr_pkg::csr_req_t       csr_req,
    input  logic [63:0]             mtime,
    input  logic [63:0]             mtimecmp,
    input  csr_pkg::csr_status_t    status,
    output csr_pkg::trap_update_t   update,
    output csr_pkg::priv_mode_e     mode,
    output logic                    csr_stall,
    output logic                    csr_trap,
    output logic [`CSR_XLEN-1:0]    csr_trap_vector
);

    logic [`CSR_ID_W-1:0]   saved_id;
    logic                   mtip_q;
    // Set while the second cycle of a redirect is due
    logic                   redirect;
    logic [`CSR_XLEN-1:0]   trap_vector_q;

    logic                   second_cycle;
    logic                   first_cycle;
    logic                   irq_pending;
    csr_pkg::trap_event_e   ev;
    logic [`CSR_XLEN-1:0]   cause;
    logic [`CSR_XLEN-1:0]   mtvec_base;
    logic [`CSR_XLEN-1:0]   target;

    // Same ID again after a stall, state already committed
    assign second_cycle = csr_valid && redirect && (csr_inst_id == saved_id);
    assign first_cycle  = csr_valid && !second_cycle;

    // Machine timer interrupt enabled and pending
    assign irq_pending = mtip_q && status.mie && status.mtie;

    // Event select, interrupt beats ECALL/MRET beats CSR op
    always_comb begin
        ev    = csr_pkg::EV_NONE;
        cause = '0;
        if (first_cycle) begin
            if (irq_pending) begin
                // Instruction's own write is dropped
                ev    = csr_pkg::EV_TRAP;
                cause = `CSR_CAUSE_MTI;
            end else begin
                case (csr_req.cmd)
                    csr_pkg::CSR_ECALL: begin
                        ev    = csr_pkg::EV_TRAP;
                        cause = (mode == csr_pkg::PRIV_USER) ?
                                `CSR_CAUSE_ECALL_U : `CSR_CAUSE_ECALL_M;
                    end
                    csr_pkg::CSR_MRET: ev = csr_pkg::EV_MRET;
                    csr_pkg::CSR_W,
                    csr_pkg::CSR_S,
                    csr_pkg::CSR_C:    ev = csr_pkg::EV_CSR_OP;
                    default:           ev = csr_pkg::EV_NONE;
                endcase
            end
        end
    end

    // Redirect target
    assign mtvec_base = {status.mtvec[`CSR_XLEN-1:2], 2'b00};

    always_comb begin
        if (ev == csr_pkg::EV_MRET) begin
            target = status.mepc;
        end else if (irq_pending && (status.mtvec[1:0] == 2'b01)) begin
            // Vectored, base + 4 * code, interrupts only
            target = mtvec_base + {cause[`CSR_XLEN-3:0], 2'b00};
        end else begin
            // Direct mode and all exceptions
            target = mtvec_base;
        end
    end

    // Order to the register file
    always_comb begin
        update.ev        = ev;
        update.cause     = cause;
        update.epc       = csr_req.pc;
        update.prev_mode = mode;
        update.mtip      = mtip_q;
    end

    // Two-cycle handshake flags
    assign csr_stall = (ev == csr_pkg::EV_TRAP) || (ev == csr_pkg::EV_MRET);
    assign csr_trap  = second_cycle;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode     <= csr_pkg::PRIV_MACHINE;
            saved_id <= `CSR_ID_RESET;
            mtip_q   <= 1'b0;
            redirect <= 1'b0;
        end else begin
            // Pending bit lags the compare by one clock
            mtip_q <= (mtime >= mtimecmp);
            if (csr_valid) begin
                saved_id <= csr_inst_id;
                redirect <= csr_stall;
            end
            case (ev)
                csr_pkg::EV_TRAP: mode <= csr_pkg::PRIV_MACHINE;
                csr_pkg::EV_MRET: mode <= status.mpp;
                default: begin
                end
            endcase
        end
    end

    // Vector held for the trap cycle
    always_ff @(posedge clk) begin
        if (csr_stall) begin
            trap_vector_q <= target;
        end
    end

    assign csr_trap_vector = trap_vector_q;

endmodule

// ==== logic/csr_regfile.sv ====
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_pkg::csr_req_t       req,
    input  csr_pkg::trap_update_t   update,
    input  csr_pkg::priv_mode_e     mode,
    input  logic                    mtip,
    input  logic [63:0]             cycle_count,
    output logic [`CSR_XLEN-1:0]    rdata,
    output csr_pkg::csr_status_t    status
);

    // Kept machine CSR state
    logic                   mstatus_mie;
    logic                   mstatus_mpie;
    csr_pkg::priv_mode_e    mstatus_mpp;
    logic                   mie_mtie;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;

    // Packed views and datapath
    logic [`CSR_XLEN-1:0]   mstatus_val;
    logic [`CSR_XLEN-1:0]   mie_val;
    logic [`CSR_XLEN-1:0]   mip_val;
    logic [`CSR_XLEN-1:0]   csr_val;
    logic [`CSR_XLEN-1:0]   wdata;
    logic                   can_read;
    logic                   can_write;

    // Privilege field of the address must not exceed the mode
    assign can_read  = req.addr[9:8] <= mode;
    // Top two bits 11 mean a read-only CSR
    assign can_write = can_read && (req.addr[11:10] != 2'b11);

    always_comb begin
        mstatus_val = '0;
        mstatus_val[`CSR_MSTATUS_MIE_BIT]     = mstatus_mie;
        mstatus_val[`CSR_MSTATUS_MPIE_BIT]    = mstatus_mpie;
        mstatus_val[`CSR_MSTATUS_MPP_LSB +: 2] = mstatus_mpp;
        mie_val = '0;
        mie_val[`CSR_MIE_MTIE_BIT] = mie_mtie;
        mip_val = '0;
        mip_val[`CSR_MIP_MTIP_BIT] = mtip;
    end

    // Read mux, unknown addresses read zero
    always_comb begin
        case (req.addr)
            `CSR_ADDR_MSTATUS:   csr_val = mstatus_val;
            `CSR_ADDR_MISA:      csr_val = `CSR_MISA_VALUE;
            `CSR_ADDR_MIE:       csr_val = mie_val;
            `CSR_ADDR_MTVEC:     csr_val = mtvec;
            `CSR_ADDR_MSCRATCH:  csr_val = mscratch;
            `CSR_ADDR_MEPC:      csr_val = mepc;
            `CSR_ADDR_MCAUSE:    csr_val = mcause;
            `CSR_ADDR_MIP:       csr_val = mip_val;
            `CSR_ADDR_CYCLE:     csr_val = cycle_count[31:0];
            `CSR_ADDR_CYCLEH:    csr_val = cycle_count[63:32];
            `CSR_ADDR_MCYCLE:    csr_val = cycle_count[31:0];
            `CSR_ADDR_MCYCLEH:   csr_val = cycle_count[63:32];
            `CSR_ADDR_MVENDORID: csr_val = '0;
            `CSR_ADDR_MARCHID:   csr_val = '0;
            `CSR_ADDR_MIMPID:    csr_val = '0;
            `CSR_ADDR_MHARTID:   csr_val = '0;
            default:             csr_val = '0;
        endcase
    end

    // Old value goes out, write commits at the edge
    assign rdata = can_read ? csr_val : '0;

    // Write, set or clear against the current value
    always_comb begin
        case (req.cmd)
            csr_pkg::CSR_W: wdata = req.op1;
            csr_pkg::CSR_S: wdata = csr_val | req.op1;
            csr_pkg::CSR_C: wdata = csr_val & ~req.op1;
            default:        wdata = csr_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::PRIV_MACHINE;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            case (update.ev)
                csr_pkg::EV_CSR_OP: begin
                    if (can_write) begin
                        case (req.addr)
                            `CSR_ADDR_MSTATUS: begin
                                mstatus_mie  <= wdata[`CSR_MSTATUS_MIE_BIT];
                                mstatus_mpie <= wdata[`CSR_MSTATUS_MPIE_BIT];
                                // Only U and M exist, anything nonzero is M
                                mstatus_mpp  <= (wdata[`CSR_MSTATUS_MPP_LSB +: 2] == 2'b00) ?
                                                csr_pkg::PRIV_USER : csr_pkg::PRIV_MACHINE;
                            end
                            `CSR_ADDR_MIE:      mie_mtie <= wdata[`CSR_MIE_MTIE_BIT];
                            `CSR_ADDR_MTVEC:    mtvec    <= wdata;
                            `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                            // IALIGN 32
                            `CSR_ADDR_MEPC:     mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                            `CSR_ADDR_MCAUSE:   mcause   <= wdata;
                            default: begin
                            end
                        endcase
                    end
                end
                csr_pkg::EV_TRAP: begin
                    mcause       <= update.cause;
                    mepc         <= update.epc;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= update.prev_mode;
                end
                csr_pkg::EV_MRET: begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    // Lowest supported mode
                    mstatus_mpp  <= csr_pkg::PRIV_USER;
                end
                default: begin
                end
            endcase
        end
    end

    // State the trap controller needs
    always_comb begin
        status.mie   = mstatus_mie;
        status.mpie  = mstatus_mpie;
        status.mpp   = mstatus_mpp;
        status.mtie  = mie_mtie;
        status.mtvec = mtvec;
        status.mepc  = mepc;
    end

endmodule

// ==== logic/csr_pkg.sv ====
`include "csr_defines.svh"

package csr_pkg;

    // CSR stage commands, values 0..3 finish in one cycle
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Encoded as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    // One instruction presented to the stage
    typedef struct packed {
        csr_cmd_e                cmd;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_XLEN-1:0]    op1;
        logic [`CSR_XLEN-1:0]    pc;
    } csr_req_t;

    // What commits at the coming clock edge
    typedef enum logic [1:0] {
        EV_NONE   = 2'd0,
        EV_CSR_OP = 2'd1,
        EV_TRAP   = 2'd2,
        EV_MRET   = 2'd3
    } trap_event_e;

    // Trap controller to register file
    typedef struct packed {
        trap_event_e             ev;
        logic [`CSR_XLEN-1:0]    cause;
        logic [`CSR_XLEN-1:0]    epc;
        priv_mode_e              prev_mode;
        // Registered timer pending, shown in mip
        logic                    mtip;
    } trap_update_t;

    // Register file state used for trap decisions
    typedef struct packed {
        logic                    mie;
        logic                    mpie;
        priv_mode_e              mpp;
        logic                    mtie;
        logic [`CSR_XLEN-1:0]    mtvec;
        logic [`CSR_XLEN-1:0]    mepc;
    } csr_status_t;

endpackage

// ==== logic/csr_defines.svh ====
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Datapath and tag widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_ID_W            64

// Saved ID out of reset, never issued by the front end
`define CSR_ID_RESET        64'hffff_0000_0000_0000

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// Counters, user and machine views
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_CYCLEH     12'hc80
`define CSR_ADDR_MCYCLE     12'hb00
`define CSR_ADDR_MCYCLEH    12'hb80

// Machine information, all read as zero
`define CSR_ADDR_MVENDORID  12'hf11
`define CSR_ADDR_MARCHID    12'hf12
`define CSR_ADDR_MIMPID     12'hf13
`define CSR_ADDR_MHARTID    12'hf14

// mcause codes, bit 31 marks an interrupt
`define CSR_CAUSE_ECALL_U   32'h0000_0008
`define CSR_CAUSE_ECALL_M   32'h0000_000b
`define CSR_CAUSE_MTI       32'h8000_0007

// MXL = 1 (RV32), extensions A, I and M
`define CSR_MISA_VALUE      32'h4000_1101

// Field positions
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB  11
`define CSR_MIE_MTIE_BIT     7
`define CSR_MIP_MTIP_BIT     7

`endif
